/* ex_stage.f */
rtl/ex_pkg.sv
rtl/ex_alu_path.sv
rtl/ex_target_path.sv
rtl/ex_mem_reg.sv
rtl/ex_stage.sv
testbench/tb_clock_gen.sv
testbench/ex_stage_assert.sv
testbench/tb_ex_stage.sv

/* Makefile */
TOP = tb_ex_stage

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): ex_stage.f rtl/*.sv testbench/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f ex_stage.f -o $(TOP)

# Assertion errors are counted, the testbench itself ends the run with $fatal.
run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

/* testbench/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int NB_DATA    = 32;
    localparam int NB_PC      = 32;
    localparam int N_INSTR    = 400;
    localparam int MAX_CYCLES = N_INSTR * 3 + 100; // longest gap gives three cycles each.

    logic               clock;
    logic               rst_n;
    logic               valid;
    ex_ctrl_t           ctrl;
    ex_in_t             ex;
    logic [NB_PC-1:0]   pc;
    logic [NB_DATA-1:0] data_a;
    logic [NB_DATA-1:0] data_b;
    logic [NB_DATA-1:0] imm;
    instr_lo_u          lo;
    logic [NB_REG-1:0]  rt;
    logic               out_valid;
    ex_ctrl_t           out_ctrl;
    logic [NB_DATA-1:0] out_alu_result;
    logic               out_zero;
    logic [NB_PC-1:0]   out_branch_address;
    logic [NB_DATA-1:0] out_store_data;
    logic [NB_REG-1:0]  out_dest_reg;

    logic [31:0] lcg_state;
    int          cycle_count = 0;
    int          sent = 0;
    int          received = 0;

    tb_clock_gen #(
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .o_clock (clock),
        .o_rst_n (rst_n)
    );

    ex_stage #(
        .NB_DATA (NB_DATA),
        .NB_PC   (NB_PC)
    ) i_ex_stage (
        .i_clock          (clock),
        .i_rst_n          (rst_n),
        .i_valid          (valid),
        .i_ctrl           (ctrl),
        .i_ex             (ex),
        .i_pc             (pc),
        .i_data_a         (data_a),
        .i_data_b         (data_b),
        .i_imm            (imm),
        .i_lo             (lo),
        .i_rt             (rt),
        .o_valid          (out_valid),
        .o_ctrl           (out_ctrl),
        .o_alu_result     (out_alu_result),
        .o_zero           (out_zero),
        .o_branch_address (out_branch_address),
        .o_store_data     (out_store_data),
        .o_dest_reg       (out_dest_reg)
    );

    bind ex_stage ex_stage_assert #(
        .NB_DATA (NB_DATA),
        .NB_PC   (NB_PC)
    ) u_assert (
        .i_clock (i_clock), .i_rst_n (i_rst_n), .i_valid (i_valid), .i_ctrl (i_ctrl),
        .i_ex (i_ex), .i_pc (i_pc), .i_data_a (i_data_a), .i_data_b (i_data_b),
        .i_imm (i_imm), .i_lo (i_lo), .i_rt (i_rt), .o_valid (o_valid), .o_ctrl (o_ctrl),
        .o_alu_result (o_alu_result), .o_zero (o_zero), .o_branch_address (o_branch_address),
        .o_store_data (o_store_data), .o_dest_reg (o_dest_reg)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // the low bits of an LCG repeat quickly, so only the upper halves are used.
    function automatic logic [31:0] random_word();
        logic [31:0] upper;
        logic [31:0] lower;
        upper = next_random();
        lower = next_random();
        return {upper[31:16], lower[31:16]};
    endfunction

    function automatic logic [5:0] pick_funct(input logic [2:0] idx);
        case (idx)
            3'd0:    return 6'h20; // add.
            3'd1:    return 6'h22; // sub.
            3'd2:    return 6'h24; // and.
            3'd3:    return 6'h25; // or.
            3'd4:    return 6'h27; // nor.
            3'd5:    return 6'h2a; // slt.
            3'd6:    return 6'h00; // sll.
            default: return 6'h21; // addu is not decoded and runs as add.
        endcase
    endfunction

    task automatic drive_instruction();
        logic [31:0] r;
        logic [31:0] offset;
        r       = next_random();
        offset  = random_word();
        data_a  = random_word();
        data_b  = (r[16:15] == 2'b00) ? data_a : random_word(); // equal operands hit zero.
        pc      = random_word();
        pc[1:0] = 2'b00;
        rt      = r[14:10];
        ctrl    = r[9:5];
        ex.reg_dst = r[4];
        ex.alu_src = r[3];
        case (r[31:30])
            2'b00: begin
                ex.alu_op = mem_add;
                lo.imm    = offset[15:0];
            end
            2'b01: begin
                ex.alu_op  = branch_sub;
                ex.alu_src = 1'b0;
                lo.imm     = offset[15:0];
            end
            default: begin
                ex.alu_op  = rtype_funct;
                ex.alu_src = 1'b0;
                ex.reg_dst = 1'b1;
                lo.imm     = {r[26:22], r[21:17], pick_funct(r[29:27])}; // rd, shamt, funct.
            end
        endcase
        imm = {{(NB_DATA-16){lo.imm[15]}}, lo.imm};
    endtask

    task automatic report_assertion_error();
        $display("[FAIL] time=%0t signal=%s got=0x%0h expected=0x%0h",
                 i_ex_stage.u_assert.err_time, i_ex_stage.u_assert.err_name,
                 i_ex_stage.u_assert.err_got, i_ex_stage.u_assert.err_exp);
        $display("Verification failed");
        $fatal(1, "assertion failure in the execute stage");
    endtask

    always @(posedge clock) begin
        if (out_valid) begin
            received <= received + 1;
        end
    end

    always @(negedge clock) begin
        if (i_ex_stage.u_assert.err_flag) begin
            report_assertion_error();
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d results seen",
                     cycle_count, received, N_INSTR);
            $display("Verification failed");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        logic [31:0] r;
        int          gap;
        lcg_state = 32'hcd4e_e696;
        valid     = 1'b0;
        ctrl      = '0;
        ex        = '0;
        pc        = '0;
        data_a    = '0;
        data_b    = '0;
        imm       = '0;
        lo        = '0;
        rt        = '0;
        // strobes under reset must never reach the memory stage.
        repeat (4) @(negedge clock);
        repeat (3) begin
            drive_instruction();
            valid = 1'b1;
            @(negedge clock);
        end
        valid = 1'b0;
        wait (rst_n);
        @(negedge clock);
        while (sent < N_INSTR) begin
            drive_instruction();
            valid = 1'b1;
            sent++;
            @(negedge clock);
            valid = 1'b0;
            r   = next_random();
            gap = (r[31:30] == 2'b11) ? 0 : int'(r[31:30]); // half of them back to back.
            repeat (gap) @(negedge clock);
        end
        while (received < N_INSTR) @(negedge clock);
        repeat (2) @(negedge clock);
        if (i_ex_stage.u_assert.err_flag) begin
            report_assertion_error();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* testbench/ex_stage_assert.sv */
`timescale 1ns/1ps

module ex_stage_assert
    import ex_pkg::*;
#(
    parameter int NB_DATA = 32,
    parameter int NB_PC   = 32
) (
    input logic               i_clock,
    input logic               i_rst_n,
    input logic               i_valid,
    input ex_ctrl_t           i_ctrl,
    input ex_in_t             i_ex,
    input logic [NB_PC-1:0]   i_pc,
    input logic [NB_DATA-1:0] i_data_a,
    input logic [NB_DATA-1:0] i_data_b,
    input logic [NB_DATA-1:0] i_imm,
    input instr_lo_u          i_lo,
    input logic [NB_REG-1:0]  i_rt,
    input logic               o_valid,
    input ex_ctrl_t           o_ctrl,
    input logic [NB_DATA-1:0] o_alu_result,
    input logic               o_zero,
    input logic [NB_PC-1:0]   o_branch_address,
    input logic [NB_DATA-1:0] o_store_data,
    input logic [NB_REG-1:0]  o_dest_reg
);

    logic               warm = 1'b0; // set after the first edge, when $past has history.
    logic               take;
    ex_ctrl_t           exp_ctrl;
    logic [NB_DATA-1:0] exp_b;
    logic [NB_DATA-1:0] exp_result;
    logic               exp_equal;
    logic [NB_PC-1:0]   exp_target;
    logic [NB_REG-1:0]  exp_dest;

    // The first failure is kept here for the testbench.
    logic        err_flag = 1'b0;
    string       err_name;
    logic [63:0] err_got;
    logic [63:0] err_exp;
    time         err_time;

    // MIPS semantics of the supported operations on the raw funct bits.
    function automatic logic [NB_DATA-1:0] mips_alu(
        input logic [1:0]         op,
        input logic [5:0]         fn,
        input logic [4:0]         sh,
        input logic [NB_DATA-1:0] a,
        input logic [NB_DATA-1:0] b
    );
        logic lt;
        lt = $signed(a) < $signed(b);
        if (op == branch_sub) return a - b;
        if (op != rtype_funct) return a + b;
        case (fn)
            6'h22:   return a - b;
            6'h24:   return a & b;
            6'h25:   return a | b;
            6'h27:   return ~(a | b);
            6'h2a:   return {{(NB_DATA-1){1'b0}}, lt};
            6'h00:   return b << sh;
            default: return a + b; // add, and any code the ALU does not know.
        endcase
    endfunction

    task automatic note_failure(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (!err_flag) begin
            err_flag = 1'b1;
            err_name = name;
            err_got  = got;
            err_exp  = exp;
            err_time = $time;
        end
    endtask

    always @(posedge i_clock) begin
        warm <= 1'b1;
    end

    assign take       = i_valid && i_rst_n; // a strobe under reset is dropped.
    assign exp_ctrl   = take ? i_ctrl : '0;
    assign exp_b      = i_ex.alu_src ? i_imm : i_data_b;
    assign exp_result = mips_alu(i_ex.alu_op, i_lo.imm[5:0], i_lo.imm[10:6], i_data_a, exp_b);
    assign exp_equal  = (i_data_a == exp_b);
    assign exp_target = i_pc + (NB_PC'(i_imm) << 2);
    assign exp_dest   = i_ex.reg_dst ? i_lo.imm[15:11] : i_rt;

    a_valid: assert property (@(posedge i_clock) warm |-> o_valid == $past(take))
        else begin
            note_failure("o_valid", 64'($sampled(o_valid)), 64'($past(take)));
            $error("o_valid does not follow the input strobe");
        end
    a_ctrl: assert property (@(posedge i_clock) warm |-> o_ctrl == $past(exp_ctrl))
        else begin
            note_failure("o_ctrl", 64'($sampled(o_ctrl)), 64'($past(exp_ctrl)));
            $error("o_ctrl does not match the strobed flags");
        end
    a_result: assert property (@(posedge i_clock)
        warm && $past(take) |-> o_alu_result == $past(exp_result))
        else begin
            note_failure("o_alu_result", 64'($sampled(o_alu_result)), 64'($past(exp_result)));
            $error("o_alu_result is wrong");
        end
    a_zero: assert property (@(posedge i_clock)
        warm && $past(take) |-> o_zero == ($past(exp_result) == '0))
        else begin
            note_failure("o_zero", 64'($sampled(o_zero)), 64'($past(exp_result) == '0));
            $error("o_zero does not reflect a zero result");
        end
    a_beq: assert property (@(posedge i_clock)
        warm && $past(take) && $past(i_ex.alu_op) == branch_sub |-> o_zero == $past(exp_equal))
        else begin
            note_failure("o_zero", 64'($sampled(o_zero)), 64'($past(exp_equal)));
            $error("o_zero does not match the beq compare");
        end
    a_target: assert property (@(posedge i_clock)
        warm && $past(take) |-> o_branch_address == $past(exp_target))
        else begin
            note_failure("o_branch_address", 64'($sampled(o_branch_address)),
                         64'($past(exp_target)));
            $error("o_branch_address is wrong");
        end
    a_dest: assert property (@(posedge i_clock)
        warm && $past(take) |-> o_dest_reg == $past(exp_dest))
        else begin
            note_failure("o_dest_reg", 64'($sampled(o_dest_reg)), 64'($past(exp_dest)));
            $error("o_dest_reg is wrong");
        end
    a_store: assert property (@(posedge i_clock)
        warm && $past(take) |-> o_store_data == $past(i_data_b))
        else begin
            note_failure("o_store_data", 64'($sampled(o_store_data)), 64'($past(i_data_b)));
            $error("o_store_data is not operand B");
        end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic o_clock,
    output logic o_rst_n
);

    initial begin
        o_clock = 1'b0;
        forever #5 o_clock = ~o_clock; // 10 ns period.
    end

    // reset is released on a falling edge, away from the sampling edge.
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clock);
        @(negedge o_clock);
        o_rst_n = 1'b1;
    end

endmodule

/* rtl/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
#(
    parameter int NB_DATA = 32,
    parameter int NB_PC   = 32
) (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  ex_ctrl_t           i_ctrl,
    input  ex_in_t             i_ex,
    input  logic [NB_PC-1:0]   i_pc,     // already PC+4.
    input  logic [NB_DATA-1:0] i_data_a,
    input  logic [NB_DATA-1:0] i_data_b,
    input  logic [NB_DATA-1:0] i_imm,    // sign-extended offset.
    input  instr_lo_u          i_lo,
    input  logic [NB_REG-1:0]  i_rt,
    output logic               o_valid,
    output ex_ctrl_t           o_ctrl,
    output logic [NB_DATA-1:0] o_alu_result,
    output logic               o_zero,
    output logic [NB_PC-1:0]   o_branch_address,
    output logic [NB_DATA-1:0] o_store_data,
    output logic [NB_REG-1:0]  o_dest_reg
);

    logic [NB_DATA-1:0] alu_result;
    logic               zero;
    logic [NB_PC-1:0]   branch_address;
    logic [NB_REG-1:0]  dest_reg;

    ex_alu_path #(
        .NB_DATA (NB_DATA)
    ) u_alu_path (
        .i_alu_op  (i_ex.alu_op),
        .i_alu_src (i_ex.alu_src),
        .i_lo      (i_lo),
        .i_data_a  (i_data_a),
        .i_data_b  (i_data_b),
        .i_imm     (i_imm),
        .o_result  (alu_result),
        .o_zero    (zero)
    );

    ex_target_path #(
        .NB_PC (NB_PC)
    ) u_target_path (
        .i_pc             (i_pc),
        .i_imm            (i_imm),
        .i_reg_dst        (i_ex.reg_dst),
        .i_rt             (i_rt),
        .i_lo             (i_lo),
        .o_branch_address (branch_address),
        .o_dest_reg       (dest_reg)
    );

    // operand B as read from the register file is what a store writes.
    ex_mem_reg #(
        .NB_DATA (NB_DATA),
        .NB_PC   (NB_PC)
    ) u_ex_mem_reg (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_valid          (i_valid),
        .i_ctrl           (i_ctrl),
        .i_alu_result     (alu_result),
        .i_zero           (zero),
        .i_branch_address (branch_address),
        .i_store_data     (i_data_b),
        .i_dest_reg       (dest_reg),
        .o_valid          (o_valid),
        .o_ctrl           (o_ctrl),
        .o_alu_result     (o_alu_result),
        .o_zero           (o_zero),
        .o_branch_address (o_branch_address),
        .o_store_data     (o_store_data),
        .o_dest_reg       (o_dest_reg)
    );

endmodule

/* rtl/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg
    import ex_pkg::*;
#(
    parameter int NB_DATA = 32,
    parameter int NB_PC   = 32
) (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  ex_ctrl_t           i_ctrl,
    input  logic [NB_DATA-1:0] i_alu_result,
    input  logic               i_zero,
    input  logic [NB_PC-1:0]   i_branch_address,
    input  logic [NB_DATA-1:0] i_store_data,
    input  logic [NB_REG-1:0]  i_dest_reg,
    output logic               o_valid,
    output ex_ctrl_t           o_ctrl,
    output logic [NB_DATA-1:0] o_alu_result,
    output logic               o_zero,
    output logic [NB_PC-1:0]   o_branch_address,
    output logic [NB_DATA-1:0] o_store_data,
    output logic [NB_REG-1:0]  o_dest_reg
);

    logic               valid_q;
    ex_mem_t            flags_q;
    logic [NB_DATA-1:0] alu_result_q;
    logic [NB_PC-1:0]   branch_address_q;
    logic [NB_DATA-1:0] store_data_q;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            flags_q <= '0;
        end else begin
            valid_q <= i_valid;
            if (i_valid) begin
                flags_q.ctrl     <= i_ctrl;
                flags_q.zero     <= i_zero;
                flags_q.dest_reg <= i_dest_reg;
            end else begin
                flags_q.ctrl <= '0; // a bubble must not write or branch.
            end
        end
    end

    // wide words are captured on a strobe and otherwise held.
    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            alu_result_q     <= i_alu_result;
            branch_address_q <= i_branch_address;
            store_data_q     <= i_store_data;
        end
    end

    assign o_valid          = valid_q;
    assign o_ctrl           = flags_q.ctrl;
    assign o_zero           = flags_q.zero;
    assign o_dest_reg       = flags_q.dest_reg;
    assign o_alu_result     = alu_result_q;
    assign o_branch_address = branch_address_q;
    assign o_store_data     = store_data_q;

endmodule

/* rtl/ex_target_path.sv */
`timescale 1ns/1ps

module ex_target_path
    import ex_pkg::*;
#(
    parameter int NB_PC = 32
) (
    input  logic [NB_PC-1:0]  i_pc,
    input  logic [NB_PC-1:0]  i_imm,
    input  logic              i_reg_dst,
    input  logic [NB_REG-1:0] i_rt,
    input  instr_lo_u         i_lo,
    output logic [NB_PC-1:0]  o_branch_address,
    output logic [NB_REG-1:0] o_dest_reg
);

    logic [NB_PC-1:0] imm_words; // offset in bytes.

    // The branch offset counts words, so it is scaled by four.
    assign imm_words = {i_imm[NB_PC-3:0], 2'b00};

    // i_pc already holds PC+4, the base of a MIPS branch.
    assign o_branch_address = i_pc + imm_words;

    // R-format writes rd, I-format writes rt.
    assign o_dest_reg = i_reg_dst ? i_lo.r.rd : i_rt;

endmodule

/* rtl/ex_alu_path.sv */
`timescale 1ns/1ps

module ex_alu_path
    import ex_pkg::*;
#(
    parameter int NB_DATA = 32
) (
    input  alu_op_e            i_alu_op,
    input  logic               i_alu_src,
    input  instr_lo_u          i_lo,
    input  logic [NB_DATA-1:0] i_data_a,
    input  logic [NB_DATA-1:0] i_data_b,
    input  logic [NB_DATA-1:0] i_imm,
    output logic [NB_DATA-1:0] o_result,
    output logic               o_zero
);

    alu_ctrl_e          alu_ctrl;
    logic [NB_DATA-1:0] operand_b;
    logic               less_than;

    // alu control combines the operation class with the funct view of the
    // instruction's low half word.
    always_comb begin
        case (i_alu_op)
            mem_add: begin
                alu_ctrl = alu_add;
            end
            branch_sub: begin
                alu_ctrl = alu_sub;
            end
            rtype_funct: begin
                case (i_lo.r.funct)
                    funct_add: alu_ctrl = alu_add;
                    funct_sub: alu_ctrl = alu_sub;
                    funct_and: alu_ctrl = alu_and;
                    funct_or:  alu_ctrl = alu_or;
                    funct_nor: alu_ctrl = alu_nor;
                    funct_slt: alu_ctrl = alu_slt;
                    funct_sll: alu_ctrl = alu_sll;
                    default:   alu_ctrl = alu_add; // unsupported funct falls back to add.
                endcase
            end
            default: begin
                alu_ctrl = alu_add;
            end
        endcase
    end

    // second operand is the register value or the sign-extended immediate.
    assign operand_b = i_alu_src ? i_imm : i_data_b;

    assign less_than = $signed(i_data_a) < $signed(operand_b); // slt compares signed.

    always_comb begin
        case (alu_ctrl)
            alu_add: begin
                o_result = i_data_a + operand_b;
            end
            alu_sub: begin
                o_result = i_data_a - operand_b;
            end
            alu_and: begin
                o_result = i_data_a & operand_b;
            end
            alu_or: begin
                o_result = i_data_a | operand_b;
            end
            alu_nor: begin
                o_result = ~(i_data_a | operand_b);
            end
            alu_slt: begin
                o_result = {{(NB_DATA-1){1'b0}}, less_than};
            end
            alu_sll: begin
                // sll shifts rt, which is operand B, by shamt.
                o_result = operand_b << i_lo.r.shamt;
            end
            default: begin
                o_result = i_data_a + operand_b;
            end
        endcase
    end

    // For branch_sub the zero flag is the beq condition.
    assign o_zero = (o_result == '0);

endmodule

/* rtl/ex_pkg.sv */
package ex_pkg;

    localparam int NB_FCODE = 6;
    localparam int NB_REG   = 5;
    localparam int NB_SHAMT = 5;

    // ALU operation class as produced by the main decoder.
    typedef enum logic [1:0] {
        mem_add     = 2'b00, // load/store effective address.
        branch_sub  = 2'b01, // beq compare.
        rtype_funct = 2'b10  // operation comes from funct.
    } alu_op_e;

    // Function codes of the R-format instructions the ALU executes.
    typedef enum logic [NB_FCODE-1:0] {
        funct_sll = 6'h00,
        funct_add = 6'h20,
        funct_sub = 6'h22,
        funct_and = 6'h24,
        funct_or  = 6'h25,
        funct_nor = 6'h27,
        funct_slt = 6'h2a
    } funct_e;

    // Internal ALU operation selected by ALU control.
    typedef enum logic [3:0] {
        alu_and = 4'b0000,
        alu_or  = 4'b0001,
        alu_add = 4'b0010,
        alu_sll = 4'b0011,
        alu_sub = 4'b0110,
        alu_slt = 4'b0111,
        alu_nor = 4'b1100
    } alu_ctrl_e;

    // low half word of an R-format instruction.
    typedef struct packed {
        logic [NB_REG-1:0]   rd;
        logic [NB_SHAMT-1:0] shamt;
        funct_e              funct;
    } r_fields_t;

    // The same 16 bits are either R-format fields or the I-format offset.
    typedef union packed {
        r_fields_t   r;
        logic [15:0] imm;
    } instr_lo_u;

    // flags that travel on to the memory and write-back stages.
    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
        logic mem_read;
        logic mem_write;
        logic branch;
    } ex_ctrl_t;

    // flags consumed inside the execute stage.
    typedef struct packed {
        logic    alu_src;
        logic    reg_dst;
        alu_op_e alu_op;
    } ex_in_t;

    // Fixed-width part of the EX/MEM bundle. The data and PC words are sized per module.
    typedef struct packed {
        ex_ctrl_t          ctrl;
        logic              zero;
        logic [NB_REG-1:0] dest_reg;
    } ex_mem_t;

endpackage
